// File: source/lsu_pkg.sv
package lsu_pkg;

  // access width of a load or store.
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_t;

  // one load/store request as issued by the core.
  typedef struct packed {
    logic         write; // 1 = store.
    logic         sext;  // sign-extend narrow loads.
    access_size_t size;
    logic [31:0]  addr;  // byte address.
    logic [31:0]  data;  // store data, low aligned.
  } lsu_req_t;

  // completion seen by the core, all fields valid with done.
  typedef struct packed {
    logic        done;
    logic        error;
    logic [31:0] data;
  } lsu_rsp_t;

endpackage

// File: source/bus_pkg.sv
package bus_pkg;

  typedef enum logic {
    bus_okay  = 1'b0,
    bus_error = 1'b1
  } bus_resp_t;

  // read address channel, word granular.
  typedef struct packed {
    logic        valid;
    logic [29:0] addr;
  } ar_chan_t;

  // write address channel.
  typedef struct packed {
    logic        valid;
    logic [29:0] addr;
  } aw_chan_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [3:0]  strb; // one bit per byte lane.
  } w_chan_t;

  typedef struct packed {
    logic        valid;
    bus_resp_t   resp;
    logic [31:0] data;
  } r_chan_t;

  typedef struct packed {
    logic      valid;
    bus_resp_t resp;
  } b_chan_t;

  // slave response delays in cycles.
  typedef struct packed {
    logic [3:0] rd_wait;
    logic [3:0] wr_wait;
  } wait_cfg_t;

endpackage

// File: source/lane_steer.sv
module lane_steer import lsu_pkg::*; (
  input  lsu_req_t    req,
  input  logic [31:0] rdata_raw,
  output logic [29:0] word_addr,
  output logic [31:0] wdata,
  output logic [3:0]  wstrb,
  output logic        misaligned,
  output logic [31:0] load_data
);

  logic [1:0]  offset;
  logic [31:0] lane;

  assign offset    = req.addr[1:0];
  assign word_addr = req.addr[31:2];

  // store data moves up to its byte lane.
  assign wdata = req.data << {offset, 3'b000};

  always_comb begin
    case (req.size)
      size_byte: wstrb = 4'b0001 << offset;
      size_half: wstrb = 4'b0011 << offset;
      default:   wstrb = 4'b1111;
    endcase
  end

  always_comb begin
    case (req.size)
      size_half: misaligned = offset[0];
      size_word: misaligned = (offset != 2'd0);
      default:   misaligned = 1'b0; // bytes fit anywhere.
    endcase
  end

  // addressed lane lands at bit 0.
  assign lane = rdata_raw >> {offset, 3'b000};

  always_comb begin
    case (req.size)
      size_byte: begin
        if (req.sext) begin
          load_data = {{24{lane[7]}}, lane[7:0]};
        end else begin
          load_data = {24'b0, lane[7:0]};
        end
      end
      size_half: begin
        if (req.sext) begin
          load_data = {{16{lane[15]}}, lane[15:0]};
        end else begin
          load_data = {16'b0, lane[15:0]};
        end
      end
      default: load_data = rdata_raw;
    endcase
  end

endmodule

// File: source/lsu_fsm.sv
module lsu_fsm import lsu_pkg::*, bus_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        req,
  input  lsu_req_t    req_data,
  input  logic        misaligned,
  input  logic [31:0] load_data,
  input  logic        arready,
  input  logic        awready,
  input  logic        wready,
  input  r_chan_t     r,
  input  b_chan_t     b,
  output logic        busy,
  output lsu_req_t    held_req,
  output ar_chan_t    ar,
  output aw_chan_t    aw,
  output w_chan_t     w,
  output logic        rready,
  output logic        bready,
  output lsu_rsp_t    rsp
);

  typedef enum logic [2:0] {
    st_idle,
    st_rd_addr,
    st_rd_data,
    st_wr_addr,
    st_wr_data,
    st_wr_resp,
    st_finish
  } state_t;

  state_t      state;
  logic        ar_valid;
  logic        aw_valid;
  logic        w_valid;
  logic        done_q;
  logic        error_q;
  logic [31:0] data_q;

  assign busy = (state != st_idle);

  // only the handshake comes from here, payload is steered at the top.
  assign ar  = '{valid: ar_valid, addr: '0};
  assign aw  = '{valid: aw_valid, addr: '0};
  assign w   = '{valid: w_valid, data: '0, strb: '0};
  assign rsp = '{done: done_q, error: error_q, data: data_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      ar_valid <= 1'b0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      rready   <= 1'b0;
      bready   <= 1'b0;
      done_q   <= 1'b0;
      error_q  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req) begin
            held_req <= req_data;
            state    <= req_data.write ? st_wr_addr : st_rd_addr;
          end
        end
        st_rd_addr: begin
          if (!ar_valid) begin
            // first cycle, alignment of the held request is known now.
            if (misaligned) begin
              done_q  <= 1'b1;
              error_q <= 1'b1;
              data_q  <= '0;
              state   <= st_finish;
            end else begin
              ar_valid <= 1'b1;
            end
          end else if (arready) begin
            ar_valid <= 1'b0;
            rready   <= 1'b1;
            state    <= st_rd_data;
          end
        end
        st_rd_data: begin
          if (r.valid && rready) begin
            rready  <= 1'b0;
            done_q  <= 1'b1;
            error_q <= (r.resp == bus_error);
            data_q  <= load_data;
            state   <= st_finish;
          end
        end
        st_wr_addr: begin
          if (!aw_valid) begin
            if (misaligned) begin
              done_q  <= 1'b1;
              error_q <= 1'b1;
              data_q  <= '0;
              state   <= st_finish;
            end else begin
              aw_valid <= 1'b1;
            end
          end else if (awready) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b1;
            state    <= st_wr_data;
          end
        end
        st_wr_data: begin
          if (w_valid && wready) begin
            w_valid <= 1'b0;
            bready  <= 1'b1;
            state   <= st_wr_resp;
          end
        end
        st_wr_resp: begin
          if (b.valid && bready) begin
            bready  <= 1'b0;
            done_q  <= 1'b1;
            error_q <= (b.resp == bus_error);
            data_q  <= '0;
            state   <= st_finish;
          end
        end
        default: begin
          done_q  <= 1'b0; // done is a single pulse.
          error_q <= 1'b0;
          state   <= st_idle;
        end
      endcase
    end
  end

endmodule

// File: source/wait_state_regs.sv
module wait_state_regs import bus_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      cfg_wen,
  input  wait_cfg_t cfg_data,
  output wait_cfg_t wait_cfg
);

  // both counts load together, effective next cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cfg <= '0;
    end else if (cfg_wen) begin
      wait_cfg <= cfg_data;
    end
  end

endmodule

// File: source/mem_slave.sv
module mem_slave import bus_pkg::*; #(
  parameter int mem_words = 256
) (
  input  logic      clk,
  input  logic      rst,
  input  wait_cfg_t wait_cfg,
  input  ar_chan_t  ar,
  input  aw_chan_t  aw,
  input  w_chan_t   w,
  input  logic      rready,
  input  logic      bready,
  output logic      arready,
  output logic      awready,
  output logic      wready,
  output r_chan_t   r,
  output b_chan_t   b
);

  localparam int idx_w = $clog2(mem_words);

  typedef enum logic [2:0] {
    st_idle,
    st_rd_wait,
    st_rd_resp,
    st_wr_wait,
    st_wr_data,
    st_wr_resp
  } state_t;

  state_t           state;
  logic [3:0]       wait_cnt;
  logic [29:0]      addr_q;
  logic [idx_w-1:0] idx;
  logic             in_range;
  logic [31:0]      mem [mem_words];

  assign idx      = addr_q[idx_w-1:0];
  assign in_range = ({2'b00, addr_q} < 32'(mem_words));

  // one address at a time, reads win a tie.
  assign arready = (state == st_idle);
  assign awready = (state == st_idle) && !ar.valid;
  assign wready  = (state == st_wr_data);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      wait_cnt <= '0;
      r.valid  <= 1'b0;
      b.valid  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (ar.valid) begin
            addr_q   <= ar.addr;
            wait_cnt <= wait_cfg.rd_wait;
            state    <= st_rd_wait;
          end else if (aw.valid) begin
            addr_q   <= aw.addr;
            wait_cnt <= wait_cfg.wr_wait;
            state    <= st_wr_wait;
          end
        end
        st_rd_wait: begin
          if (wait_cnt == 4'd0) begin
            r.valid <= 1'b1;
            r.resp  <= in_range ? bus_okay : bus_error;
            r.data  <= in_range ? mem[idx] : '0; // out of range reads zero.
            state   <= st_rd_resp;
          end else begin
            wait_cnt <= wait_cnt - 4'd1;
          end
        end
        st_rd_resp: begin
          if (rready) begin
            r.valid <= 1'b0;
            state   <= st_idle;
          end
        end
        st_wr_wait: begin
          if (wait_cnt == 4'd0) begin
            state <= st_wr_data;
          end else begin
            wait_cnt <= wait_cnt - 4'd1;
          end
        end
        st_wr_data: begin
          if (w.valid) begin
            b.valid <= 1'b1;
            b.resp  <= in_range ? bus_okay : bus_error;
            state   <= st_wr_resp;
          end
        end
        default: begin
          if (bready) begin
            b.valid <= 1'b0;
            state   <= st_idle;
          end
        end
      endcase
    end
  end

  // per-lane write, dropped when out of range.
  always_ff @(posedge clk) begin
    if (state == st_wr_data && w.valid && in_range) begin
      for (int i = 0; i < 4; i++) begin
        if (w.strb[i]) begin
          mem[idx][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
  end

endmodule

// File: source/lsu_subsys_top.sv
module lsu_subsys_top import lsu_pkg::*, bus_pkg::*; #(
  parameter int mem_words = 256
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  lsu_req_t  req_data,
  input  logic      cfg_wen,
  input  wait_cfg_t cfg_data,
  output logic      busy,
  output lsu_rsp_t  rsp
);

  lsu_req_t    held_req;
  logic [29:0] word_addr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        misaligned;
  logic [31:0] load_data;
  ar_chan_t    fsm_ar;
  aw_chan_t    fsm_aw;
  w_chan_t     fsm_w;
  ar_chan_t    ar;
  aw_chan_t    aw;
  w_chan_t     w;
  r_chan_t     r;
  b_chan_t     b;
  logic        arready;
  logic        awready;
  logic        wready;
  logic        rready;
  logic        bready;
  wait_cfg_t   wait_cfg;

  // bus channels take valid from the FSM and payload from lane steering.
  assign ar = '{valid: fsm_ar.valid, addr: word_addr};
  assign aw = '{valid: fsm_aw.valid, addr: word_addr};
  assign w  = '{valid: fsm_w.valid, data: wdata, strb: wstrb};

  lsu_fsm lsu_fsm_i (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_data   (req_data),
    .misaligned (misaligned),
    .load_data  (load_data),
    .arready    (arready),
    .awready    (awready),
    .wready     (wready),
    .r          (r),
    .b          (b),
    .busy       (busy),
    .held_req   (held_req),
    .ar         (fsm_ar),
    .aw         (fsm_aw),
    .w          (fsm_w),
    .rready     (rready),
    .bready     (bready),
    .rsp        (rsp)
  );

  lane_steer lane_steer_i (
    .req        (held_req),
    .rdata_raw  (r.data),
    .word_addr  (word_addr),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .misaligned (misaligned),
    .load_data  (load_data)
  );

  wait_state_regs wait_state_regs_i (
    .clk      (clk),
    .rst      (rst),
    .cfg_wen  (cfg_wen),
    .cfg_data (cfg_data),
    .wait_cfg (wait_cfg)
  );

  mem_slave #(
    .mem_words (mem_words)
  ) mem_slave_i (
    .clk      (clk),
    .rst      (rst),
    .wait_cfg (wait_cfg),
    .ar       (ar),
    .aw       (aw),
    .w        (w),
    .rready   (rready),
    .bready   (bready),
    .arready  (arready),
    .awready  (awready),
    .wready   (wready),
    .r        (r),
    .b        (b)
  );

endmodule

// File: testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one request with its wait setup and expected response.
typedef struct packed {
  wait_cfg_t   cfg;
  lsu_req_t    req;
  logic        rnd;      // store data from the lfsr.
  logic        mdl;      // expected load from the reference memory.
  logic        exp_err;
  logic [31:0] exp_data;
} vec_t;

localparam int num_vec = 26;

// cfg {rd, wr}, {write, sext, size, addr, data}, rnd, mdl, exp_err, exp_data.
localparam vec_t vectors [num_vec] = '{
  '{8'h00, '{1'b1, 1'b0, size_word, 32'h010, 32'hdead_beef}, 1'b0, 1'b0, 1'b0, 32'h0},
  '{8'h00, '{1'b0, 1'b0, size_word, 32'h010, 32'h0}, 1'b0, 1'b0, 1'b0, 32'hdead_beef},
  '{8'h00, '{1'b1, 1'b0, size_word, 32'h020, 32'h1122_3344}, 1'b0, 1'b0, 1'b0, 32'h0},
  '{8'h00, '{1'b1, 1'b0, size_byte, 32'h020, 32'h0}, 1'b1, 1'b0, 1'b0, 32'h0},
  '{8'h00, '{1'b1, 1'b0, size_byte, 32'h021, 32'h0}, 1'b1, 1'b0, 1'b0, 32'h0},
  '{8'h00, '{1'b1, 1'b0, size_half, 32'h022, 32'h0}, 1'b1, 1'b0, 1'b0, 32'h0},
  '{8'h00, '{1'b1, 1'b0, size_byte, 32'h023, 32'h0}, 1'b1, 1'b0, 1'b0, 32'h0},
  '{8'h00, '{1'b0, 1'b1, size_byte, 32'h020, 32'h0}, 1'b0, 1'b1, 1'b0, 32'h0},
  '{8'h00, '{1'b0, 1'b1, size_byte, 32'h021, 32'h0}, 1'b0, 1'b1, 1'b0, 32'h0},
  '{8'h00, '{1'b0, 1'b0, size_byte, 32'h023, 32'h0}, 1'b0, 1'b1, 1'b0, 32'h0},
  '{8'h00, '{1'b0, 1'b1, size_half, 32'h022, 32'h0}, 1'b0, 1'b1, 1'b0, 32'h0},
  '{8'h00, '{1'b0, 1'b0, size_word, 32'h020, 32'h0}, 1'b0, 1'b1, 1'b0, 32'h0},
  '{8'h00, '{1'b1, 1'b0, size_half, 32'h010, 32'h0000_80e1}, 1'b0, 1'b0, 1'b0, 32'h0},
  '{8'h00, '{1'b0, 1'b1, size_byte, 32'h011, 32'h0}, 1'b0, 1'b0, 1'b0, 32'hffff_ff80},
  '{8'h00, '{1'b0, 1'b0, size_half, 32'h010, 32'h0}, 1'b0, 1'b0, 1'b0, 32'h0000_80e1},
  '{8'h00, '{1'b0, 1'b0, size_byte, 32'h011, 32'h0}, 1'b0, 1'b0, 1'b0, 32'h0000_0080},
  '{8'h00, '{1'b0, 1'b1, size_half, 32'h010, 32'h0}, 1'b0, 1'b0, 1'b0, 32'hffff_80e1},
  '{8'h00, '{1'b1, 1'b0, size_half, 32'h011, 32'h0000_ffff}, 1'b0, 1'b0, 1'b1, 32'h0},
  '{8'h00, '{1'b0, 1'b0, size_word, 32'h013, 32'h0}, 1'b0, 1'b0, 1'b1, 32'h0},
  '{8'h00, '{1'b0, 1'b0, size_word, 32'h010, 32'h0}, 1'b0, 1'b0, 1'b0, 32'hdead_80e1},
  '{8'h00, '{1'b1, 1'b0, size_word, 32'h400, 32'h1234_5678}, 1'b0, 1'b0, 1'b1, 32'h0},
  '{8'h00, '{1'b0, 1'b0, size_word, 32'h400, 32'h0}, 1'b0, 1'b0, 1'b1, 32'h0},
  '{8'h35, '{1'b1, 1'b0, size_word, 32'h040, 32'h0bad_f00d}, 1'b0, 1'b0, 1'b0, 32'h0},
  '{8'hf2, '{1'b0, 1'b1, size_half, 32'h042, 32'h0}, 1'b0, 1'b0, 1'b0, 32'h0000_0bad},
  '{8'h2f, '{1'b1, 1'b0, size_byte, 32'h042, 32'h0}, 1'b1, 1'b0, 1'b0, 32'h0},
  '{8'h00, '{1'b0, 1'b1, size_byte, 32'h042, 32'h0}, 1'b0, 1'b1, 1'b0, 32'h0}
};

`endif

// File: testbench/tb_lsu_subsys.sv
module tb_lsu_subsys import lsu_pkg::*, bus_pkg::*; ();

  localparam int clk_period   = 4;
  localparam int reset_cycles = 16;

  logic        clk;
  logic        rst;
  logic        req;
  lsu_req_t    req_data;
  logic        cfg_wen;
  wait_cfg_t   cfg_data;
  logic        busy;
  lsu_rsp_t    rsp;
  logic [31:0] lfsr;
  logic [31:0] ref_mem [256];
  int          errors = 0;

  `include "tb_vectors.svh"

  lsu_subsys_top #(
    .mem_words (256)
  ) dut_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_data (req_data),
    .cfg_wen  (cfg_wen),
    .cfg_data (cfg_data),
    .busy     (busy),
    .rsp      (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] value;
    for (int i = 0; i < 32; i++) begin
      lfsr     = lfsr_step(lfsr);
      value[i] = lfsr[0]; // one step per bit.
    end
    return value;
  endfunction

  // lane k of the store data goes to byte offset + k.
  task automatic store_model(input lsu_req_t r);
    int off;
    int n;
    off = r.addr[1:0];
    n   = (r.size == size_byte) ? 1 : (r.size == size_half) ? 2 : 4;
    for (int k = 0; k < n; k++) begin
      ref_mem[r.addr[9:2]][8*(off+k) +: 8] = r.data[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] expected_load(input lsu_req_t r);
    logic [31:0] word;
    logic [7:0]  lo;
    logic [7:0]  hi;
    word = ref_mem[r.addr[9:2]];
    lo   = word[8*r.addr[1:0] +: 8];
    hi   = word[8*(r.addr[1:0]+1) +: 8];
    if (r.size == size_byte) return r.sext ? {{24{lo[7]}}, lo} : {24'h0, lo};
    if (r.size == size_half) return r.sext ? {{16{hi[7]}}, hi, lo} : {16'h0, hi, lo};
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic run_entry(input vec_t v);
    lsu_req_t    r;
    logic        misal;
    int          lat_exp;
    int          cycles;
    logic [31:0] exp_data;
    r = v.req;
    if (v.rnd) r.data = random_word();
    misal = (r.size == size_half && r.addr[0]) || (r.size == size_word && r.addr[1:0] != 2'd0);
    if (misal) lat_exp = 1;
    else if (r.write) lat_exp = 5 + v.cfg.wr_wait;
    else lat_exp = 4 + v.cfg.rd_wait;
    exp_data = v.mdl ? expected_load(r) : v.exp_data;
    if (r.write && !misal && r.addr[31:2] < 256) store_model(r);
    cfg_wen  = 1'b1;
    cfg_data = v.cfg;
    @(negedge clk);
    cfg_wen  = 1'b0;
    req      = 1'b1;
    req_data = r;
    @(negedge clk);
    req    = 1'b0;
    cycles = 0;
    while (!rsp.done) begin
      check_value("busy", 1, busy);
      @(negedge clk);
      cycles++;
    end
    check_value("busy", 1, busy);
    check_value("rsp.error", v.exp_err, rsp.error);
    check_value("rsp.data", exp_data, rsp.data);
    check_value("rsp.done cycles", lat_exp, cycles);
    @(negedge clk);
    check_value("busy", 0, busy); // idle again after the pulse.
    check_value("rsp.done", 0, rsp.done);
  endtask

  initial begin
    rst      = 1'b1;
    req      = 1'b0;
    req_data = '0;
    cfg_wen  = 1'b0;
    cfg_data = '0;
    lfsr     = 32'd70270;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    check_value("busy", 0, busy);
    check_value("rsp.done", 0, rsp.done);
    for (int i = 0; i < num_vec; i++) begin
      run_entry(vectors[i]);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // slowest entry plus cfg, req and idle cycles.
  initial begin
    #(clk_period * (reset_cycles + num_vec * (5 + 15 + 4)));
    $display("timeout, done never arrived");
    $display("test failed");
    $finish;
  end

endmodule

// File: all.f
+incdir+testbench
source/lsu_pkg.sv
source/bus_pkg.sv
source/lane_steer.sv
source/lsu_fsm.sv
source/wait_state_regs.sv
source/mem_slave.sv
source/lsu_subsys_top.sv
testbench/tb_lsu_subsys.sv

// File: Bender.yml
package:
  name: lsu_subsys

sources:
  - source/lsu_pkg.sv
  - source/bus_pkg.sv
  - source/lane_steer.sv
  - source/lsu_fsm.sv
  - source/wait_state_regs.sv
  - source/mem_slave.sv
  - source/lsu_subsys_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_lsu_subsys.sv
